//--- run_sim.sh
#!/bin/sh
# Build the CCL testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ccl -f vlog.f -o tb_ccl \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_ccl 2>&1)
echo "$out"
echo "$out" | grep -q "^All checks passed$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tests/ccl_sva.sv
`default_nettype none
`timescale 1ns/100ps

module ccl_sva (
    input logic clk,
    input logic reset,
    input logic sram_wen,
    input logic finish
);

    int err_count = 0;

    // Finish is sticky until the next reset
    finish_holds: assert property (
        @(posedge clk) disable iff (reset) finish |=> finish
    ) else begin
        $error("finish dropped without a reset");
        err_count++;
    end

    no_write_after_finish: assert property (
        @(posedge clk) disable iff (reset) finish |-> sram_wen
    ) else begin
        $error("SRAM write strobe low after finish");
        err_count++;
    end

    quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> sram_wen
    ) else begin
        $error("SRAM write strobe low in the first cycle after reset");
        err_count++;
    end

endmodule

bind ccl_top ccl_sva u_ccl_sva (
    .clk      (clk),
    .reset    (reset),
    .sram_wen (sram_wen),
    .finish   (finish)
);

`default_nettype wire

//--- tests/tb_ccl.sv
`default_nettype none
`timescale 1ns/100ps

module tb_ccl
    import ccl_pkg::*;
();

    localparam int label_w   = 9;
    localparam int npix      = img_w * img_w;
    localparam int num_tests = 14;
    // Row overhead of both passes plus a full merge for every pixel
    localparam int cycle_limit = num_tests * (2 * img_w * 40 + npix * (2 ** label_w + 4));

    logic       clk = 1'b0;
    logic       reset;
    logic [7:0] rom_q = 8'h00;
    rom_addr_t  rom_a;
    sram_addr_t sram_a;
    logic [7:0] sram_d;
    logic       sram_wen;
    logic       finish;

    logic [img_w-1:0] img_rows [img_w];
    logic [7:0]       sram_mem [npix];
    sram_addr_t       wr_count [npix];
    int               ref_map [npix];
    int               fill_stack [npix];
    int               ref_count;
    integer           seed;
    int               cycles = 0;
    int               error_count = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    bit               compared;

    always #50 clk = ~clk;

    ccl_top u_ccl_top (
        .clk      (clk),
        .reset    (reset),
        .rom_q    (rom_q),
        .rom_a    (rom_a),
        .sram_a   (sram_a),
        .sram_d   (sram_d),
        .sram_wen (sram_wen),
        .finish   (finish)
    );

    // Column 0 is the MSB of the first byte of a row
    function automatic logic [7:0] rom_byte(input rom_addr_t a);
        logic [img_w-1:0] bits;
        int               sel;
        bits = img_rows[int'(a) / bytes_per_row];
        sel = bytes_per_row - 1 - int'(a) % bytes_per_row;
        return bits[8 * sel +: 8];
    endfunction

    function automatic bit pixel_at(input int r, input int c);
        return img_rows[r][img_w - 1 - c];
    endfunction

    // Flood fill under 8-connectivity that returns the component count
    function automatic int label_reference();
        int n;
        int sp;
        int p;
        int q;
        int nr;
        int nc;
        n = 0;
        for (int i = 0; i < npix; i++) begin
            ref_map[i] = 0;
        end
        for (int i = 0; i < npix; i++) begin
            if (pixel_at(i / img_w, i % img_w) && ref_map[i] == 0) begin
                n++;
                ref_map[i] = n;
                fill_stack[0] = i;
                sp = 1;
                while (sp > 0) begin
                    sp--;
                    p = fill_stack[sp];
                    for (int dr = -1; dr <= 1; dr++) begin
                        for (int dc = -1; dc <= 1; dc++) begin
                            nr = p / img_w + dr;
                            nc = p % img_w + dc;
                            q = nr * img_w + nc;
                            if (nr >= 0 && nr < img_w && nc >= 0 && nc < img_w
                                && pixel_at(nr, nc) && ref_map[q] == 0) begin
                                ref_map[q] = n;
                                fill_stack[sp] = q;
                                sp++;
                            end
                        end
                    end
                end
            end
        end
        return n;
    endfunction

    // ROM answers one cycle after the address
    always @(posedge clk) begin
        rom_q <= rom_byte(rom_a);
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < npix; i++) begin
                wr_count[i] <= '0;
            end
        end else if (!sram_wen) begin
            sram_mem[sram_a] <= sram_d;
            wr_count[sram_a] <= wr_count[sram_a] + 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_label(input sram_addr_t addr, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: pixel row %0d col %0d has label %0d, expected %0d",
                     $time, addr / img_w, addr % img_w, got, exp);
            error_count++;
        end
    endtask

    task automatic check_writes(input sram_addr_t addr, input sram_addr_t count);
        if (count !== sram_addr_t'(1)) begin
            $display("ERROR at %0t: address %0d written %0d times, expected 1",
                     $time, addr, count);
            error_count++;
        end
    endtask

    // Labels are arbitrary, so compare the partition through a component map
    task automatic compare_result();
        logic [7:0] ref_to_dut [npix + 1];
        bit         ref_seen [npix + 1];
        int         dut_owner [256];
        logic [7:0] got;
        logic [7:0] exp;
        int         k;
        for (int i = 0; i <= npix; i++) begin
            ref_seen[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            dut_owner[i] = 0;
        end
        for (int p = 0; p < npix; p++) begin
            got = sram_mem[p];
            k = ref_map[p];
            check_writes(sram_addr_t'(p), wr_count[p]);
            if (k == 0) begin
                exp = 8'd0;
            end else if (ref_seen[k]) begin
                exp = ref_to_dut[k];
            end else begin
                if (got == 8'd0 || $isunknown(got) || dut_owner[got] != 0) begin
                    $display("ERROR at %0t: component %0d starts with label %0d, %s",
                             $time, k, got, "which is background or already taken");
                    error_count++;
                end else begin
                    dut_owner[got] = k;
                end
                ref_seen[k] = 1'b1;
                ref_to_dut[k] = got;
                exp = got;
            end
            check_label(sram_addr_t'(p), got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            compared <= 1'b0;
        end else if (finish && !compared) begin
            compare_result();
            compared <= 1'b1;
        end
    end

    task automatic clear_image();
        for (int r = 0; r < img_w; r++) begin
            img_rows[r] = '0;
        end
    endtask

    task automatic set_pixel(input int r, input int c);
        img_rows[r][img_w - 1 - c] = 1'b1;
    endtask

    task automatic fill_rect(input int r0, input int c0, input int r1, input int c1);
        for (int r = r0; r <= r1; r++) begin
            for (int c = c0; c <= c1; c++) begin
                set_pixel(r, c);
            end
        end
    endtask

    // About 40% foreground and redrawn while labels would not fit in a byte
    task automatic draw_random();
        int n;
        n = 256;
        while (n > 255) begin
            clear_image();
            for (int r = 0; r < img_w; r++) begin
                for (int c = 0; c < img_w; c++) begin
                    if ($unsigned($random(seed)) % 100 < 40) begin
                        set_pixel(r, c);
                    end
                end
            end
            n = label_reference();
        end
    endtask

    task automatic run_test(input string name);
        int errs_before;
        errs_before = error_count;
        ref_count = label_reference();
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) begin
            @(posedge clk);
        end
        reset <= 1'b0;
        while (!compared) begin
            @(posedge clk);
        end
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %0d %s: %0d components, ok", tests_run, name, ref_count);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d components, %0d errors",
                     tests_run, name, ref_count, error_count - errs_before);
        end
    endtask

    initial begin
        reset = 1'b1;
        seed = 32'he20f_c95f;

        clear_image();
        run_test("empty image");

        fill_rect(0, 0, img_w - 1, img_w - 1);
        run_test("full image");

        // U with arms on columns 2 and 8 and a comb with teeth on even columns
        clear_image();
        fill_rect(2, 2, 12, 2);
        fill_rect(2, 8, 12, 8);
        fill_rect(12, 2, 12, 8);
        for (int c = 14; c <= 28; c += 2) begin
            fill_rect(2, c, 10, c);
        end
        fill_rect(11, 14, 11, 28);
        run_test("u shape and comb");

        // X and V made of corner-touching pixels, plus separate blobs
        clear_image();
        for (int r = 0; r <= 10; r++) begin
            set_pixel(r, 1 + r);
            set_pixel(r, 11 - r);
        end
        for (int r = 0; r <= 6; r++) begin
            set_pixel(14 + r, 14 + r);
            set_pixel(14 + r, 26 - r);
        end
        fill_rect(24, 2, 26, 4);
        fill_rect(24, 8, 26, 10);
        set_pixel(0, 30);
        set_pixel(28, 15);
        set_pixel(31, 31);
        run_test("diagonals and blobs");

        for (int i = 0; i < 10; i++) begin
            draw_random();
            run_test($sformatf("random image %0d", i));
        end

        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, error_count, u_ccl_top.u_ccl_sva.err_count);
        if (tests_failed == 0 && error_count == 0 && u_ccl_top.u_ccl_sva.err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/ccl_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module ccl_ctrl
    import ccl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       conflict,
    input  logic       tbl_done,
    output rom_addr_t  rom_a,
    output lab_cmd_t   cmd,
    output tbl_op_e    tbl_op,
    output sram_addr_t sram_a,
    output logic       sram_wen,
    output logic       finish
);

    ctrl_state_e state;
    ctrl_state_e state_n;
    ctrl_state_e ret_state;

    // 0 for the merge pass, 1 for the write pass
    logic       pass;
    row_t       row;
    col_t       col;
    logic [2:0] ld_cnt;
    logic       merge_req;

    // Write pipeline from label to lookup to SRAM strobe
    logic       lookup_pend;
    sram_addr_t wr_addr;

    assign merge_req = !pass && conflict;

    always_comb begin
        state_n = state;
        cmd.op = OP_NONE;
        cmd.byte_sel = ld_cnt[1:0] - 2'd1;
        cmd.col = col;
        cmd.first_row = (row == '0);
        tbl_op = lookup_pend ? TBL_LOOKUP : TBL_NONE;

        case (state)
            IDLE: begin
                state_n = LOAD;
            end

            LOAD: begin
                // Byte n arrives one cycle after its address
                if (ld_cnt != '0) begin
                    cmd.op = OP_LOAD_BYTE;
                end
                if (ld_cnt == 3'(bytes_per_row)) begin
                    state_n = LABEL;
                end
            end

            LABEL: begin
                if (merge_req) begin
                    tbl_op = TBL_MERGE_START;
                    state_n = MERGE;
                end else begin
                    cmd.op = OP_LABEL;
                    if (col == col_t'(img_w - 1)) begin
                        state_n = SHIFT;
                    end
                end
            end

            MERGE: begin
                if (tbl_done) begin
                    state_n = ret_state;
                end
            end

            SHIFT: begin
                // Conflict from the last column still needs its merge
                if (merge_req) begin
                    tbl_op = TBL_MERGE_START;
                    state_n = MERGE;
                end else if (row == row_t'(img_w - 1)) begin
                    if (!pass) begin
                        cmd.op = OP_CLEAR;
                        tbl_op = TBL_RESOLVE_START;
                        state_n = RESOLVE;
                    end else begin
                        state_n = FINISH;
                    end
                end else begin
                    cmd.op = OP_SHIFT_ROW;
                    state_n = LOAD;
                end
            end

            RESOLVE: begin
                if (tbl_done) begin
                    state_n = LOAD;
                end
            end

            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            ret_state <= LABEL;
            pass <= 1'b0;
            row <= '0;
            col <= '0;
            ld_cnt <= '0;
            rom_a <= '0;
            lookup_pend <= 1'b0;
            sram_wen <= 1'b1;
            finish <= 1'b0;
        end else begin
            state <= state_n;
            if (tbl_op == TBL_MERGE_START) begin
                ret_state <= state;
            end
            if (state == LOAD) begin
                if (ld_cnt == 3'(bytes_per_row)) begin
                    ld_cnt <= '0;
                end else begin
                    ld_cnt <= ld_cnt + 3'd1;
                end
                // Wraps to 0 after the last row, ready for pass 2
                if (ld_cnt < 3'(bytes_per_row)) begin
                    rom_a <= rom_a + 1'b1;
                end
            end
            if (cmd.op == OP_LABEL) begin
                col <= col + 1'b1;
            end
            if (state == SHIFT && state_n != MERGE) begin
                row <= row + 1'b1;
            end
            if (state == RESOLVE && tbl_done) begin
                pass <= 1'b1;
            end
            lookup_pend <= pass && (cmd.op == OP_LABEL);
            sram_wen <= !lookup_pend;
            if (state == FINISH) begin
                finish <= 1'b1;
            end
        end
    end

    // Address follows the same two stages as the strobe
    always_ff @(posedge clk) begin
        wr_addr <= {row, col};
        sram_a <= wr_addr;
    end

endmodule

`default_nettype wire

//--- verilog/ccl_pkg.sv
`default_nettype none

package ccl_pkg;

    // Image geometry with 1 bit per pixel in the ROM
    parameter int img_w         = 32;
    parameter int bytes_per_row = 4;

    typedef logic [$clog2(img_w)-1:0]         col_t;
    typedef logic [$clog2(img_w)-1:0]         row_t;
    typedef logic [$clog2(img_w * bytes_per_row)-1:0] rom_addr_t;
    typedef logic [$clog2(img_w * img_w)-1:0] sram_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        LABEL,
        MERGE,
        SHIFT,
        RESOLVE,
        FINISH
    } ctrl_state_e;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_LOAD_BYTE,
        OP_LABEL,
        OP_SHIFT_ROW,
        OP_CLEAR
    } lab_op_e;

    typedef enum logic [1:0] {
        TBL_NONE,
        TBL_MERGE_START,
        TBL_RESOLVE_START,
        TBL_LOOKUP
    } tbl_op_e;

    // Controller to labeler
    typedef struct packed {
        lab_op_e    op;
        logic [1:0] byte_sel;
        col_t       col;
        logic       first_row;
    } lab_cmd_t;

endpackage

`default_nettype wire

//--- verilog/ccl_top.sv
`default_nettype none
`timescale 1ns/100ps

module ccl_top
    import ccl_pkg::*;
#(
    parameter int label_w = 9
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rom_q,
    output rom_addr_t  rom_a,
    output sram_addr_t sram_a,
    output logic [7:0] sram_d,
    output logic       sram_wen,
    output logic       finish
);

    lab_cmd_t           cmd;
    tbl_op_e            tbl_op;
    logic               conflict;
    logic               tbl_done;
    logic [label_w-1:0] lo;
    logic [label_w-1:0] hi;
    logic [label_w-1:0] pixel_label;

    ccl_ctrl u_ccl_ctrl (
        .clk      (clk),
        .reset    (reset),
        .conflict (conflict),
        .tbl_done (tbl_done),
        .rom_a    (rom_a),
        .cmd      (cmd),
        .tbl_op   (tbl_op),
        .sram_a   (sram_a),
        .sram_wen (sram_wen),
        .finish   (finish)
    );

    line_labeler #(
        .label_w (label_w)
    ) u_line_labeler (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .rom_q       (rom_q),
        .pixel_label (pixel_label),
        .conflict    (conflict),
        .lo          (lo),
        .hi          (hi)
    );

    equiv_table #(
        .label_w (label_w)
    ) u_equiv_table (
        .clk         (clk),
        .reset       (reset),
        .tbl_op      (tbl_op),
        .lo          (lo),
        .hi          (hi),
        .pixel_label (pixel_label),
        .tbl_done    (tbl_done),
        .sram_d      (sram_d)
    );

endmodule

`default_nettype wire

//--- verilog/equiv_table.sv
`default_nettype none
`timescale 1ns/100ps

module equiv_table
    import ccl_pkg::*;
#(
    parameter int label_w = 9
) (
    input  logic               clk,
    input  logic               reset,
    input  tbl_op_e            tbl_op,
    input  logic [label_w-1:0] lo,
    input  logic [label_w-1:0] hi,
    input  logic [label_w-1:0] pixel_label,
    output logic               tbl_done,
    output logic [7:0]         sram_d
);

    localparam int depth = 2 ** label_w;

    // Entry 0 marks a label that is its own representative
    logic [label_w-1:0] tbl [depth];

    logic [label_w-1:0] lo_q;
    logic [label_w-1:0] hi_q;
    logic [label_w-1:0] small_q;
    logic [label_w-1:0] big_q;
    logic [label_w-1:0] idx;
    logic               find;
    logic               scan;
    logic               resolve;

    logic [label_w-1:0] rep_lo;
    logic [label_w-1:0] rep_hi;
    logic [label_w-1:0] rep_min;
    logic [label_w-1:0] rep_max;

    // Flat table so one read gives the representative
    assign rep_lo = (tbl[lo_q] == '0) ? lo_q : tbl[lo_q];
    assign rep_hi = (tbl[hi_q] == '0) ? hi_q : tbl[hi_q];
    assign rep_min = (rep_lo < rep_hi) ? rep_lo : rep_hi;
    assign rep_max = (rep_lo < rep_hi) ? rep_hi : rep_lo;

    assign tbl_done = (find && rep_lo == rep_hi) || ((scan || resolve) && &idx);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            find <= 1'b0;
            scan <= 1'b0;
            resolve <= 1'b0;
            idx <= '0;
            for (int i = 0; i < depth; i++) begin
                tbl[i] <= '0;
            end
        end else begin
            if (tbl_op == TBL_MERGE_START) begin
                find <= 1'b1;
            end
            if (tbl_op == TBL_RESOLVE_START) begin
                resolve <= 1'b1;
                idx <= '0;
            end

            // Both representatives point at the smaller one before the scan
            if (find) begin
                find <= 1'b0;
                if (rep_lo != rep_hi) begin
                    tbl[rep_max] <= rep_min;
                    tbl[rep_min] <= rep_min;
                    scan <= 1'b1;
                    idx <= '0;
                end
            end

            if (scan) begin
                if (tbl[idx] == big_q) begin
                    tbl[idx] <= small_q;
                end
                idx <= idx + 1'b1;
                if (&idx) begin
                    scan <= 1'b0;
                end
            end

            if (resolve) begin
                if (tbl[idx] == '0) begin
                    tbl[idx] <= idx;
                end
                idx <= idx + 1'b1;
                if (&idx) begin
                    resolve <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_op == TBL_MERGE_START) begin
            lo_q <= lo;
            hi_q <= hi;
        end
        if (find) begin
            small_q <= rep_min;
            big_q <= rep_max;
        end
        // Only the low byte reaches the SRAM
        if (tbl_op == TBL_LOOKUP) begin
            sram_d <= (pixel_label == '0) ? 8'd0 : 8'(tbl[pixel_label]);
        end
    end

endmodule

`default_nettype wire

//--- verilog/line_labeler.sv
`default_nettype none
`timescale 1ns/100ps

module line_labeler
    import ccl_pkg::*;
#(
    parameter int label_w = 9
) (
    input  logic               clk,
    input  logic               reset,
    input  lab_cmd_t           cmd,
    input  logic [7:0]         rom_q,
    output logic [label_w-1:0] pixel_label,
    output logic               conflict,
    output logic [label_w-1:0] lo,
    output logic [label_w-1:0] hi
);

    // Column 0 sits in the MSB, as in the ROM
    logic [img_w-1:0]   row_bits;
    logic [label_w-1:0] prev_lab [img_w];
    logic [label_w-1:0] cur_lab  [img_w];
    logic [label_w-1:0] label_cnt;

    col_t col_m1;
    col_t col_p1;
    col_t bit_idx;
    logic fg;

    logic [label_w-1:0] left;
    logic [label_w-1:0] up_left;
    logic [label_w-1:0] up;
    logic [label_w-1:0] up_right;
    logic [label_w-1:0] pick;
    logic               from_lu;
    logic               new_label;
    logic               clash;

    assign col_m1 = cmd.col - col_t'(1);
    assign col_p1 = cmd.col + col_t'(1);
    assign bit_idx = col_t'(img_w - 1) - cmd.col;
    assign fg = row_bits[bit_idx];

    // Neighbors outside the image read as 0
    always_comb begin
        left = (cmd.col != '0) ? cur_lab[col_m1] : '0;
        up = cmd.first_row ? '0 : prev_lab[cmd.col];
        up_left = (cmd.first_row || cmd.col == '0) ? '0 : prev_lab[col_m1];
        if (cmd.first_row || cmd.col == col_t'(img_w - 1)) begin
            up_right = '0;
        end else begin
            up_right = prev_lab[col_p1];
        end
    end

    always_comb begin
        pick = label_cnt;
        from_lu = 1'b1;
        new_label = 1'b0;
        if (left != '0) begin
            pick = left;
        end else if (up_left != '0) begin
            pick = up_left;
        end else begin
            from_lu = 1'b0;
            if (up != '0) begin
                pick = up;
            end else if (up_right != '0) begin
                pick = up_right;
            end else begin
                new_label = 1'b1;
            end
        end
        // Up-right is only adjacent to up, never to left or up-left
        clash = from_lu && (up_right != '0) && (up_right != pick);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            label_cnt <= label_w'(1);
            conflict <= 1'b0;
        end else begin
            conflict <= 1'b0;
            case (cmd.op)
                OP_LABEL: begin
                    conflict <= fg && clash;
                    if (fg && new_label) begin
                        label_cnt <= label_cnt + 1'b1;
                    end
                end
                OP_CLEAR: begin
                    label_cnt <= label_w'(1);
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (cmd.op)
            OP_LOAD_BYTE: begin
                row_bits[8 * (bytes_per_row - 1 - int'(cmd.byte_sel)) +: 8] <= rom_q;
            end
            OP_LABEL: begin
                cur_lab[cmd.col] <= fg ? pick : '0;
                pixel_label <= fg ? pick : '0;
                lo <= (pick < up_right) ? pick : up_right;
                hi <= (pick < up_right) ? up_right : pick;
            end
            OP_SHIFT_ROW: begin
                for (int i = 0; i < img_w; i++) begin
                    prev_lab[i] <= cur_lab[i];
                    cur_lab[i] <= '0;
                end
            end
            OP_CLEAR: begin
                for (int i = 0; i < img_w; i++) begin
                    prev_lab[i] <= '0;
                    cur_lab[i] <= '0;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/ccl_pkg.sv
verilog/ccl_ctrl.sv
verilog/line_labeler.sv
verilog/equiv_table.sv
verilog/ccl_top.sv
tests/ccl_sva.sv
tests/tb_ccl.sv
